// ==== rx_fifo.f ====
+incdir+.
rx_fifo_pkg.sv
axis_byte_packer.sv
axis_frame_fifo.sv
axis_rr_frame_mux.sv
rx_fifo.sv
tb_rx_fifo.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the rx_fifo testbench with Verilator and runs it; exit status follows the simulation
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_rx_fifo -f rx_fifo.f -o sim_rx_fifo
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/sim_rx_fifo
run_status=$?
if [ $run_status -ne 0 ]; then
    echo "Simulation ended with status $run_status"
    exit 1
fi

echo "Simulation ended cleanly"
exit 0

// ==== tb_rx_fifo.sv ====
// Directed testbench for rx_fifo; sizes from the cfg header, stops at the first mismatch or timeout
`timescale 1ns/1ps
`default_nettype none

`include "rx_fifo_cfg.svh"

module tb_rx_fifo;

    localparam int PORTS     = `RX_FIFO_PORTS;
    localparam int MAX_FRAME = 4 * `RX_FIFO_DEPTH;
    localparam int HS_LIMIT  = 5000;
    localparam int OUT_LIMIT = 20000;

    logic                          clk;
    logic                          rst;
    logic [PORTS*8-1:0]            s_axis_tdata;
    logic [PORTS-1:0]              s_axis_tvalid;
    logic [PORTS-1:0]              s_axis_tready;
    logic [PORTS-1:0]              s_axis_tlast;
    logic [PORTS-1:0]              s_axis_tuser;
    rx_fifo_pkg::word_t            m_axis_tdata;
    rx_fifo_pkg::keep_t            m_axis_tkeep;
    logic                          m_axis_tvalid;
    logic                          m_axis_tready;
    logic                          m_axis_tlast;
    rx_fifo_pkg::port_id_t         m_axis_tid;
    logic [PORTS-1:0]              status_overflow;
    logic [PORTS-1:0]              status_bad_frame;
    logic [PORTS-1:0]              status_good_frame;

    // Scoreboard, expected and received bytes per source port
    logic [7:0]                    exp_bytes [PORTS][$];
    int                            exp_lens [PORTS][$];
    logic [7:0]                    rx_bytes [PORTS][$];
    int                            rx_lens [PORTS][$];
    logic [7:0]                    cur_bytes [$];
    rx_fifo_pkg::keep_t            keep_log [$];
    int                            good_cnt [PORTS];
    int                            bad_cnt [PORTS];
    int                            ovf_cnt [PORTS];
    int                            rx_frames;
    logic                          in_frame;
    rx_fifo_pkg::port_id_t         cur_tid;
    logic                          ready_toggle;

    rx_fifo rx_fifo_inst (
        .clk               (clk),
        .rst               (rst),
        .s_axis_tdata      (s_axis_tdata),
        .s_axis_tvalid     (s_axis_tvalid),
        .s_axis_tready     (s_axis_tready),
        .s_axis_tlast      (s_axis_tlast),
        .s_axis_tuser      (s_axis_tuser),
        .m_axis_tdata      (m_axis_tdata),
        .m_axis_tkeep      (m_axis_tkeep),
        .m_axis_tvalid     (m_axis_tvalid),
        .m_axis_tready     (m_axis_tready),
        .m_axis_tlast      (m_axis_tlast),
        .m_axis_tid        (m_axis_tid),
        .status_overflow   (status_overflow),
        .status_bad_frame  (status_bad_frame),
        .status_good_frame (status_good_frame)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // Output side, sampled at the falling edge where everything is settled
    always @(negedge clk) begin
        if (!rst) begin
            for (int p = 0; p < PORTS; p++) begin
                good_cnt[p] += int'(status_good_frame[p]);
                bad_cnt[p]  += int'(status_bad_frame[p]);
                ovf_cnt[p]  += int'(status_overflow[p]);
            end
            if (m_axis_tvalid && m_axis_tready) begin
                // A frame must not change source before its tlast
                if (in_frame) begin
                    check_value("m_axis_tid", 32'(m_axis_tid), 32'(cur_tid));
                end
                cur_tid = m_axis_tid;
                keep_log.push_back(m_axis_tkeep);
                if (!m_axis_tlast) begin
                    check_value("m_axis_tkeep", 32'(m_axis_tkeep), 32'hF);
                end else if (m_axis_tkeep == '0) begin
                    abort_run("Last output word of a frame carries no valid byte");
                end else begin
                    check_value("m_axis_tkeep", 32'(m_axis_tkeep),
                                (32'd1 << $countones(m_axis_tkeep)) - 32'd1);
                end
                for (int i = 0; i < 4; i++) begin
                    if (m_axis_tkeep[i]) begin
                        cur_bytes.push_back(m_axis_tdata[i*8 +: 8]);
                    end
                end
                if (m_axis_tlast) begin
                    rx_lens[cur_tid].push_back(cur_bytes.size());
                    foreach (cur_bytes[i]) begin
                        rx_bytes[cur_tid].push_back(cur_bytes[i]);
                    end
                    cur_bytes.delete();
                    rx_frames++;
                    in_frame = 1'b0;
                end else begin
                    in_frame = 1'b1;
                end
            end
        end
    end

    // Random output back-pressure for the stress test
    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (ready_toggle) begin
                m_axis_tready = ($urandom % 2) != 0;
            end
        end
    end

    task automatic clear_scoreboard();
        for (int p = 0; p < PORTS; p++) begin
            exp_bytes[p].delete();
            exp_lens[p].delete();
            rx_bytes[p].delete();
            rx_lens[p].delete();
            good_cnt[p] = 0;
            bad_cnt[p]  = 0;
            ovf_cnt[p]  = 0;
        end
        keep_log.delete();
        rx_frames = 0;
    endtask

    // Called 1 ns after a rising edge, returns 1 ns after the edge of the transfer
    task automatic wait_handshake(input int p);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (!s_axis_tready[p]) begin
            cnt++;
            if (cnt > HS_LIMIT) begin
                abort_run($sformatf("Input port %0d never became ready", p));
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic send_frame(input int p, input int len, input bit bad, input bit expect_out,
                              input bit gaps);
        logic [7:0] data_q [$];
        for (int i = 0; i < len; i++) begin
            data_q.push_back(8'($urandom));
        end
        if (expect_out) begin
            foreach (data_q[i]) begin
                exp_bytes[p].push_back(data_q[i]);
            end
            exp_lens[p].push_back(len);
        end
        for (int i = 0; i < len; i++) begin
            if (gaps && ($urandom % 4 == 0)) begin
                s_axis_tvalid[p] = 1'b0;
                @(posedge clk);
                #1;
            end
            s_axis_tdata[p*8 +: 8] = data_q[i];
            s_axis_tlast[p]        = (i == len - 1);
            s_axis_tuser[p]        = bad && (i == len - 1);
            s_axis_tvalid[p]       = 1'b1;
            wait_handshake(p);
        end
        s_axis_tvalid[p] = 1'b0;
        s_axis_tlast[p]  = 1'b0;
        s_axis_tuser[p]  = 1'b0;
    endtask

    task automatic send_burst(input int p, input int frames, input int max_len, input bit gaps);
        for (int f = 0; f < frames; f++) begin
            send_frame(p, 1 + int'($urandom % max_len), 1'b0, 1'b1, gaps);
        end
    endtask

    task automatic wait_output();
        int total;
        int cnt;
        total = 0;
        cnt   = 0;
        for (int p = 0; p < PORTS; p++) begin
            total += exp_lens[p].size();
        end
        while (rx_frames < total) begin
            cnt++;
            if (cnt > OUT_LIMIT) begin
                abort_run($sformatf("Timed out with %0d of %0d frames out", rx_frames, total));
            end
            @(posedge clk);
        end
        // Let any late status pulse settle
        repeat (4) @(posedge clk);
        #1;
    endtask

    task automatic check_frames();
        for (int p = 0; p < PORTS; p++) begin
            check_value($sformatf("m_axis_tid %0d frame count", p),
                        rx_lens[p].size(), exp_lens[p].size());
            for (int f = 0; f < exp_lens[p].size(); f++) begin
                check_value($sformatf("m_axis_tid %0d frame %0d length", p, f),
                            rx_lens[p][f], exp_lens[p][f]);
            end
            for (int i = 0; i < exp_bytes[p].size(); i++) begin
                check_value($sformatf("m_axis_tdata port %0d byte %0d", p, i),
                            32'(rx_bytes[p][i]), 32'(exp_bytes[p][i]));
            end
        end
    endtask

    // Pulse counts for every port against the expected numbers
    task automatic check_status(input int good_exp [PORTS], input int bad_exp [PORTS],
                                input int ovf_exp [PORTS]);
        for (int p = 0; p < PORTS; p++) begin
            check_value($sformatf("status_good_frame[%0d] pulses", p), good_cnt[p], good_exp[p]);
            check_value($sformatf("status_bad_frame[%0d] pulses", p), bad_cnt[p], bad_exp[p]);
            check_value($sformatf("status_overflow[%0d] pulses", p), ovf_cnt[p], ovf_exp[p]);
        end
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_value("m_axis_tvalid", 32'(m_axis_tvalid), 0);
        check_value("status_overflow", 32'(status_overflow), 0);
        check_value("status_bad_frame", 32'(status_bad_frame), 0);
        check_value("status_good_frame", 32'(status_good_frame), 0);
        check_value("s_axis_tready", 32'(s_axis_tready), (32'd1 << PORTS) - 32'd1);
        @(posedge clk);
        #1;
    endtask

    task automatic test_single_frame();
        clear_scoreboard();
        send_frame(0, 10, 1'b0, 1'b1, 1'b0);
        wait_output();
        check_frames();
        check_value("m_axis_tkeep word count", keep_log.size(), 3);
        check_value("m_axis_tkeep word 0", 32'(keep_log[0]), 32'hF);
        check_value("m_axis_tkeep word 1", 32'(keep_log[1]), 32'hF);
        check_value("m_axis_tkeep word 2", 32'(keep_log[2]), 32'h3);
        check_status('{1, 0, 0, 0}, '{0, 0, 0, 0}, '{0, 0, 0, 0});
    endtask

    task automatic test_bad_frame();
        clear_scoreboard();
        send_frame(2, 9, 1'b1, 1'b0, 1'b0);
        send_frame(2, 13, 1'b0, 1'b1, 1'b0);
        wait_output();
        check_frames();
        check_status('{0, 0, 1, 0}, '{0, 0, 1, 0}, '{0, 0, 0, 0});
    endtask

    task automatic test_all_ports(input bit random_ready);
        clear_scoreboard();
        ready_toggle = random_ready;
        fork
            send_burst(0, 4, 40, random_ready);
            send_burst(1, 4, 40, random_ready);
            send_burst(2, 4, 40, random_ready);
            send_burst(3, 4, 40, random_ready);
        join
        wait_output();
        ready_toggle = 1'b0;
        @(posedge clk);
        #1;
        m_axis_tready = 1'b1;
        check_frames();
        check_status('{4, 4, 4, 4}, '{0, 0, 0, 0}, '{0, 0, 0, 0});
    endtask

    task automatic test_oversize();
        clear_scoreboard();
        send_frame(1, MAX_FRAME + 44, 1'b0, 1'b0, 1'b0);
        send_frame(1, 7, 1'b0, 1'b1, 1'b0);
        wait_output();
        check_frames();
        check_status('{0, 1, 0, 0}, '{0, 0, 0, 0}, '{0, 1, 0, 0});
    endtask

    initial begin
        void'($urandom(13939));
        rst           = 1'b1;
        s_axis_tdata  = '0;
        s_axis_tvalid = '0;
        s_axis_tlast  = '0;
        s_axis_tuser  = '0;
        m_axis_tready = 1'b1;
        ready_toggle  = 1'b0;
        in_frame      = 1'b0;
        cur_tid       = '0;
        clear_scoreboard();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset_state();
        test_single_frame();
        test_bad_frame();
        test_all_ports(1'b0);
        test_all_ports(1'b1);
        test_oversize();

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rx_fifo.sv ====
// Receive aggregator top; each port gets its own packer and frame FIFO, sizes come from the cfg header
`timescale 1ns/1ps
`default_nettype none

`include "rx_fifo_cfg.svh"

module rx_fifo (
    input  wire logic                                       clk,
    input  wire logic                                       rst,

    input  wire logic [`RX_FIFO_PORTS*`RX_FIFO_S_WIDTH-1:0] s_axis_tdata,
    input  wire logic [`RX_FIFO_PORTS-1:0]                  s_axis_tvalid,
    output logic [`RX_FIFO_PORTS-1:0]                       s_axis_tready,
    input  wire logic [`RX_FIFO_PORTS-1:0]                  s_axis_tlast,
    input  wire logic [`RX_FIFO_PORTS-1:0]                  s_axis_tuser,

    output rx_fifo_pkg::word_t                              m_axis_tdata,
    output rx_fifo_pkg::keep_t                              m_axis_tkeep,
    output logic                                            m_axis_tvalid,
    input  wire logic                                       m_axis_tready,
    output logic                                            m_axis_tlast,
    output rx_fifo_pkg::port_id_t                           m_axis_tid,

    output logic [`RX_FIFO_PORTS-1:0]                       status_overflow,
    output logic [`RX_FIFO_PORTS-1:0]                       status_bad_frame,
    output logic [`RX_FIFO_PORTS-1:0]                       status_good_frame
);

    // Packer to FIFO
    rx_fifo_pkg::word_t [`RX_FIFO_PORTS-1:0] pk_tdata;
    rx_fifo_pkg::keep_t [`RX_FIFO_PORTS-1:0] pk_tkeep;
    logic [`RX_FIFO_PORTS-1:0]               pk_tvalid;
    logic [`RX_FIFO_PORTS-1:0]               pk_tready;
    logic [`RX_FIFO_PORTS-1:0]               pk_tlast;
    logic [`RX_FIFO_PORTS-1:0]               pk_tuser;

    // FIFO to mux
    rx_fifo_pkg::word_t [`RX_FIFO_PORTS-1:0] fifo_tdata;
    rx_fifo_pkg::keep_t [`RX_FIFO_PORTS-1:0] fifo_tkeep;
    logic [`RX_FIFO_PORTS-1:0]               fifo_tvalid;
    logic [`RX_FIFO_PORTS-1:0]               fifo_tready;
    logic [`RX_FIFO_PORTS-1:0]               fifo_tlast;

    for (genvar n = 0; n < `RX_FIFO_PORTS; n++) begin : port

        axis_byte_packer packer_inst (
            .clk      (clk),
            .rst      (rst),
            .s_tdata  (s_axis_tdata[n*`RX_FIFO_S_WIDTH +: `RX_FIFO_S_WIDTH]),
            .s_tvalid (s_axis_tvalid[n]),
            .s_tready (s_axis_tready[n]),
            .s_tlast  (s_axis_tlast[n]),
            .s_tuser  (s_axis_tuser[n]),
            .m_tdata  (pk_tdata[n]),
            .m_tkeep  (pk_tkeep[n]),
            .m_tvalid (pk_tvalid[n]),
            .m_tready (pk_tready[n]),
            .m_tlast  (pk_tlast[n]),
            .m_tuser  (pk_tuser[n])
        );

        axis_frame_fifo #(
            .DEPTH (`RX_FIFO_DEPTH)
        ) fifo_inst (
            .clk               (clk),
            .rst               (rst),
            .s_tdata           (pk_tdata[n]),
            .s_tkeep           (pk_tkeep[n]),
            .s_tvalid          (pk_tvalid[n]),
            .s_tready          (pk_tready[n]),
            .s_tlast           (pk_tlast[n]),
            .s_tuser           (pk_tuser[n]),
            .m_tdata           (fifo_tdata[n]),
            .m_tkeep           (fifo_tkeep[n]),
            .m_tvalid          (fifo_tvalid[n]),
            .m_tready          (fifo_tready[n]),
            .m_tlast           (fifo_tlast[n]),
            .status_overflow   (status_overflow[n]),
            .status_bad_frame  (status_bad_frame[n]),
            .status_good_frame (status_good_frame[n])
        );

    end

    axis_rr_frame_mux mux_inst (
        .clk      (clk),
        .rst      (rst),
        .s_tdata  (fifo_tdata),
        .s_tkeep  (fifo_tkeep),
        .s_tvalid (fifo_tvalid),
        .s_tready (fifo_tready),
        .s_tlast  (fifo_tlast),
        .m_tdata  (m_axis_tdata),
        .m_tkeep  (m_axis_tkeep),
        .m_tvalid (m_axis_tvalid),
        .m_tready (m_axis_tready),
        .m_tlast  (m_axis_tlast),
        .m_tid    (m_axis_tid)
    );

endmodule

`default_nettype wire

// ==== axis_rr_frame_mux.sv ====
// Round-robin frame merge; a granted port keeps the output until its tlast, so one long frame blocks the rest
`timescale 1ns/1ps
`default_nettype none

`include "rx_fifo_cfg.svh"

module axis_rr_frame_mux (
    input  wire logic                                     clk,
    input  wire logic                                     rst,

    input  wire rx_fifo_pkg::word_t [`RX_FIFO_PORTS-1:0] s_tdata,
    input  wire rx_fifo_pkg::keep_t [`RX_FIFO_PORTS-1:0] s_tkeep,
    input  wire logic [`RX_FIFO_PORTS-1:0]               s_tvalid,
    output logic [`RX_FIFO_PORTS-1:0]                    s_tready,
    input  wire logic [`RX_FIFO_PORTS-1:0]               s_tlast,

    output rx_fifo_pkg::word_t                            m_tdata,
    output rx_fifo_pkg::keep_t                            m_tkeep,
    output logic                                          m_tvalid,
    input  wire logic                                     m_tready,
    output logic                                          m_tlast,
    output rx_fifo_pkg::port_id_t                         m_tid
);

    localparam int PORTS = `RX_FIFO_PORTS;

    rx_fifo_pkg::port_id_t grant;
    rx_fifo_pkg::port_id_t pick;
    rx_fifo_pkg::port_id_t sel;
    logic                  locked;
    logic                  found;
    logic                  out_ready;
    logic                  take;

    // Search starts one past the last grant and wraps back to it
    always_comb begin
        pick  = grant;
        found = 1'b0;
        for (int i = 1; i <= PORTS; i++) begin
            if (!found && s_tvalid[(int'(grant) + i) % PORTS]) begin
                pick  = rx_fifo_pkg::port_id_t'((int'(grant) + i) % PORTS);
                found = 1'b1;
            end
        end
    end

    // Held for the whole frame
    assign sel       = locked ? grant : pick;
    assign out_ready = !m_tvalid || m_tready;
    assign take      = s_tvalid[sel] && out_ready;

    always_comb begin
        for (int p = 0; p < PORTS; p++) begin
            s_tready[p] = out_ready && (int'(sel) == p);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant    <= rx_fifo_pkg::port_id_t'(PORTS - 1);
            locked   <= 1'b0;
            m_tvalid <= 1'b0;
        end else begin
            if (m_tvalid && m_tready) begin
                m_tvalid <= 1'b0;
            end
            if (take) begin
                m_tvalid <= 1'b1;
                grant    <= sel;
                // Release after the last word of the frame
                locked   <= !s_tlast[sel];
            end
        end
    end

    // Output register, source index goes out as tid
    always_ff @(posedge clk) begin
        if (take) begin
            m_tdata <= s_tdata[sel];
            m_tkeep <= s_tkeep[sel];
            m_tlast <= s_tlast[sel];
            m_tid   <= sel;
        end
    end

endmodule

`default_nettype wire

// ==== axis_frame_fifo.sv ====
// Store-and-forward frame FIFO; DEPTH must be a power of two no larger than `RX_FIFO_DEPTH
`timescale 1ns/1ps
`default_nettype none

`include "rx_fifo_cfg.svh"

module axis_frame_fifo #(
    parameter int DEPTH = `RX_FIFO_DEPTH
) (
    input  wire logic               clk,
    input  wire logic               rst,

    input  wire rx_fifo_pkg::word_t s_tdata,
    input  wire rx_fifo_pkg::keep_t s_tkeep,
    input  wire logic               s_tvalid,
    output logic                    s_tready,
    input  wire logic               s_tlast,
    input  wire logic               s_tuser,

    output rx_fifo_pkg::word_t      m_tdata,
    output rx_fifo_pkg::keep_t      m_tkeep,
    output logic                    m_tvalid,
    input  wire logic               m_tready,
    output logic                    m_tlast,

    output logic                    status_overflow,
    output logic                    status_bad_frame,
    output logic                    status_good_frame
);

    localparam int AW = $clog2(DEPTH);

    rx_fifo_pkg::word_t     mem_data [DEPTH];
    rx_fifo_pkg::keep_t     mem_keep [DEPTH];
    logic                   mem_last [DEPTH];

    rx_fifo_pkg::fifo_addr_t wr_ptr;
    rx_fifo_pkg::fifo_addr_t wr_ptr_commit;
    rx_fifo_pkg::fifo_addr_t rd_ptr;

    logic drop_frame;
    logic full;
    logic s_accept;
    logic wr_en;
    logic rd_load;

    // Occupancy counts uncommitted words too
    assign full = (wr_ptr - rd_ptr) == rx_fifo_pkg::fifo_addr_t'(DEPTH);

    // Full with nothing committed means the frame can never fit, so keep accepting and drop it
    assign s_tready = !full || (wr_ptr_commit == rd_ptr);
    assign s_accept = s_tvalid && s_tready;
    assign wr_en    = s_accept && !drop_frame && !full;

    // Only committed words are visible to the read stage
    assign rd_load  = (rd_ptr != wr_ptr_commit) && (!m_tvalid || m_tready);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_data[wr_ptr[AW-1:0]] <= s_tdata;
            mem_keep[wr_ptr[AW-1:0]] <= s_tkeep;
            mem_last[wr_ptr[AW-1:0]] <= s_tlast;
        end
    end

    // Write side with commit and rollback
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr            <= '0;
            wr_ptr_commit     <= '0;
            drop_frame        <= 1'b0;
            status_overflow   <= 1'b0;
            status_bad_frame  <= 1'b0;
            status_good_frame <= 1'b0;
        end else begin
            status_overflow   <= 1'b0;
            status_bad_frame  <= 1'b0;
            status_good_frame <= 1'b0;
            if (s_accept) begin
                if (drop_frame) begin
                    if (s_tlast) begin
                        drop_frame      <= 1'b0;
                        status_overflow <= 1'b1;
                    end
                end else if (full) begin
                    // Oversize frame, discard what was written
                    wr_ptr <= wr_ptr_commit;
                    if (s_tlast) begin
                        status_overflow <= 1'b1;
                    end else begin
                        drop_frame <= 1'b1;
                    end
                end else if (s_tlast && s_tuser) begin
                    wr_ptr           <= wr_ptr_commit;
                    status_bad_frame <= 1'b1;
                end else if (s_tlast) begin
                    wr_ptr            <= wr_ptr + 1'b1;
                    wr_ptr_commit     <= wr_ptr + 1'b1;
                    status_good_frame <= 1'b1;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
        end
    end

    // Read stage control
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr   <= '0;
            m_tvalid <= 1'b0;
        end else begin
            if (m_tvalid && m_tready) begin
                m_tvalid <= 1'b0;
            end
            if (rd_load) begin
                m_tvalid <= 1'b1;
                rd_ptr   <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_load) begin
            m_tdata <= mem_data[rd_ptr[AW-1:0]];
            m_tkeep <= mem_keep[rd_ptr[AW-1:0]];
            m_tlast <= mem_last[rd_ptr[AW-1:0]];
        end
    end

endmodule

`default_nettype wire

// ==== axis_byte_packer.sv ====
// Packs one byte stream into words; a frame always starts at lane 0 and a short last word is zero-padded
`timescale 1ns/1ps
`default_nettype none

`include "rx_fifo_cfg.svh"

module axis_byte_packer (
    input  wire logic                        clk,
    input  wire logic                        rst,

    input  wire logic [`RX_FIFO_S_WIDTH-1:0] s_tdata,
    input  wire logic                        s_tvalid,
    output logic                             s_tready,
    input  wire logic                        s_tlast,
    input  wire logic                        s_tuser,

    output rx_fifo_pkg::word_t               m_tdata,
    output rx_fifo_pkg::keep_t               m_tkeep,
    output logic                             m_tvalid,
    input  wire logic                        m_tready,
    output logic                             m_tlast,
    output logic                             m_tuser
);

    localparam int S_W    = `RX_FIFO_S_WIDTH;
    localparam int LANES  = `RX_FIFO_M_WIDTH / `RX_FIFO_S_WIDTH;
    localparam int LANE_W = $clog2(LANES);

    logic [LANE_W-1:0]  lane;
    rx_fifo_pkg::word_t stage_data;
    rx_fifo_pkg::word_t next_word;
    rx_fifo_pkg::keep_t next_keep;
    logic               s_accept;
    logic               word_done;

    // Output word empty or leaving this cycle
    assign s_tready  = !m_tvalid || m_tready;
    assign s_accept  = s_tvalid && s_tready;
    assign word_done = (lane == LANE_W'(LANES - 1)) || s_tlast;

    // Staged lanes below the current one, the new byte, zeros above
    always_comb begin
        next_word = '0;
        next_keep = '0;
        for (int i = 0; i < LANES; i++) begin
            if (i < int'(lane)) begin
                next_word[i*S_W +: S_W] = stage_data[i*S_W +: S_W];
            end else if (i == int'(lane)) begin
                next_word[i*S_W +: S_W] = s_tdata;
            end
            if (i <= int'(lane)) begin
                next_keep[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lane     <= '0;
            m_tvalid <= 1'b0;
        end else begin
            if (m_tvalid && m_tready) begin
                m_tvalid <= 1'b0;
            end
            if (s_accept) begin
                if (word_done) begin
                    m_tvalid <= 1'b1;
                    lane     <= '0;
                end else begin
                    lane <= lane + 1'b1;
                end
            end
        end
    end

    // Data path
    always_ff @(posedge clk) begin
        if (s_accept) begin
            if (word_done) begin
                m_tdata <= next_word;
                m_tkeep <= next_keep;
                m_tlast <= s_tlast;
                // Bad-frame flag only counts on the last byte
                m_tuser <= s_tlast && s_tuser;
            end else begin
                stage_data[int'(lane)*S_W +: S_W] <= s_tdata;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rx_fifo_pkg.sv ====
// Shared types sized from the cfg header; port_id_t assumes at least two ports
`default_nettype none

`include "rx_fifo_cfg.svh"

package rx_fifo_pkg;

    // One stored word, byte 0 in the low bits
    typedef logic [`RX_FIFO_M_WIDTH-1:0] word_t;

    // One bit per byte lane, valid lanes packed from lane 0
    typedef logic [`RX_FIFO_M_WIDTH/8-1:0] keep_t;

    // Source port index, carried out as tid
    typedef logic [$clog2(`RX_FIFO_PORTS)-1:0] port_id_t;

    // FIFO pointer with one extra wrap bit
    typedef logic [$clog2(`RX_FIFO_DEPTH):0] fifo_addr_t;

endpackage

`default_nettype wire

// ==== rx_fifo_cfg.svh ====
// Build-time sizes for the aggregator; FIFO depth must be a power of two, input width stays one byte
`ifndef RX_FIFO_CFG_SVH
`define RX_FIFO_CFG_SVH

// Number of byte-wide input streams
`define RX_FIFO_PORTS 4

// Input data width, one byte per transfer
`define RX_FIFO_S_WIDTH 8

// Width of the stored and merged output word
`define RX_FIFO_M_WIDTH 32

// Words per port FIFO, power of two
`define RX_FIFO_DEPTH 64

`endif
